// ==== files.f ====
hdl/ahb_subsys_pkg.sv
hdl/axil_req_front.sv
hdl/ahb_master.sv
hdl/ahb_sram.sv
hdl/axil_resp_back.sv
hdl/axil_ahb_subsys.sv
verification/tb_clk_gen.sv
verification/axil_ahb_props.sv
verification/tb_axil_ahb.sv

// ==== hdl/ahb_master.sv ====
module ahb_master
    import ahb_subsys_pkg::*;
(
    input  logic       i_clk_ahb,
    input  logic       i_rstn_ahb,
    // Request side
    input  logic       i_req_valid,
    input  ahb_req_t   i_req,
    output logic       o_req_ready,
    // Completion side
    output logic       o_done_valid,
    output ahb_done_t  o_done,
    input  logic       i_done_ready,
    // AHB-Lite master port
    output addr_t      o_haddr,
    output htrans_t    o_htrans,
    output logic       o_hwrite,
    output logic [2:0] o_hsize,
    output data_t      o_hwdata,
    input  data_t      i_hrdata,
    input  logic       i_hready,
    input  logic       i_hresp
);

    mst_state_t state, state_nxt;                // Bus-drive FSM
    logic       a_vld, a_vld_nxt;                // Address-phase request held
    ahb_req_t   a_req;                           // Address-phase request
    logic       d_vld, d_vld_nxt;                // Data phase in progress
    logic       d_write;                         // Data-phase direction
    data_t      d_wdata;                         // Data-phase write data
    logic       take;                            // Request accepted
    logic       adv;                             // Address phase sampled by slave
    logic       err_1st;                         // First ERROR cycle

    // ******************************
    // Pipeline control
    // ******************************
    assign adv     = (state == NONSEQ) & i_hready;
    assign err_1st = d_vld & ~i_hready & i_hresp;

    // Only one transfer per kind in flight so a back-end slot is always free on completion
    assign o_req_ready = i_hready & i_done_ready & ~d_vld
                       & ~(a_vld & (a_req.is_write == i_req.is_write));
    assign take        = i_req_valid & o_req_ready;

    always_comb begin
        a_vld_nxt = take ? 1'b1 : (adv ? 1'b0 : a_vld);
        d_vld_nxt = adv | (d_vld & ~i_hready);   // Held through wait states
        case (state)
            IDLE, NONSEQ: begin
                if (err_1st) begin
                    state_nxt = ERR2;            // Cancel pending address phase
                end else begin
                    state_nxt = a_vld_nxt ? NONSEQ : IDLE;
                end
            end
            ERR2:    state_nxt = a_vld_nxt ? NONSEQ : IDLE; // Reissue held request
            default: state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge i_clk_ahb or negedge i_rstn_ahb) begin
        if (!i_rstn_ahb) begin
            state <= IDLE;
            a_vld <= 1'b0;
            d_vld <= 1'b0;
        end else begin
            state <= state_nxt;
            a_vld <= a_vld_nxt;
            d_vld <= d_vld_nxt;
        end
    end

    always_ff @(posedge i_clk_ahb) begin
        if (take) begin
            a_req <= i_req;
        end
        if (adv) begin
            d_write <= a_req.is_write;           // Address phase moves to data phase
            d_wdata <= a_req.wdata;
        end
    end

    // ******************************
    // Bus and completion outputs
    // ******************************
    assign o_haddr  = a_req.addr;
    assign o_hwrite = a_req.is_write;
    assign o_htrans = (state == NONSEQ) ? HTRANS_NONSEQ : HTRANS_IDLE;
    assign o_hsize  = HSIZE_WORD;                // Word transfers only
    assign o_hwdata = d_wdata;                   // One cycle behind haddr

    assign o_done_valid    = d_vld & i_hready;   // Data phase ends
    // With no data phase, expose the waiting request's kind for the slot check
    assign o_done.is_write = d_vld ? d_write : i_req.is_write;
    assign o_done.err      = i_hresp;
    assign o_done.rdata    = i_hrdata;

endmodule

// ==== hdl/ahb_sram.sv ====
module ahb_sram
    import ahb_subsys_pkg::*;
(
    input  logic       i_clk_ahb,
    input  logic       i_rstn_ahb,
    input  addr_t      i_haddr,
    input  htrans_t    i_htrans,
    input  logic       i_hwrite,
    input  logic [2:0] i_hsize,
    input  data_t      i_hwdata,
    output data_t      o_hrdata,
    output logic       o_hready,
    output logic       o_hresp
);

    data_t     mem [MEM_WORDS];                  // Word storage
    logic      d_act;                            // Data phase active
    logic      d_err;                            // Data phase gets ERROR
    logic      d_write;                          // Data-phase direction
    mem_idx_t  d_idx;                            // Data-phase word index
    wait_cnt_t cnt;                              // Cycles spent with hready low
    logic      sample;                           // Address phase accepted

    // ******************************
    // Response timing
    // ******************************
    always_comb begin
        if (!d_act) begin
            o_hready = 1'b1;                     // Idle bus, always ready
        end else if (d_err) begin
            o_hready = (cnt != '0);              // Two-cycle ERROR
        end else begin
            o_hready = (cnt == WAIT_STATES);
        end
    end

    assign o_hresp  = d_act & d_err;
    assign o_hrdata = mem[d_idx];
    assign sample   = (i_htrans == HTRANS_NONSEQ) & o_hready;

    always_ff @(posedge i_clk_ahb or negedge i_rstn_ahb) begin
        if (!i_rstn_ahb) begin
            d_act <= 1'b0;
            cnt   <= '0;
        end else if (sample) begin
            d_act <= 1'b1;                       // Next data phase starts
            cnt   <= '0;
        end else if (o_hready) begin
            d_act <= 1'b0;
        end else begin
            cnt <= cnt + 1'b1;                   // Stretch data phase
        end
    end

    always_ff @(posedge i_clk_ahb) begin
        if (sample) begin
            d_err   <= (i_haddr >= MEM_BYTES) || (i_hsize != HSIZE_WORD);
            d_write <= i_hwrite;
            d_idx   <= i_haddr[IDX_W+1:2];       // Byte to word address
        end
    end

    // Storage, cleared on reset
    always_ff @(posedge i_clk_ahb or negedge i_rstn_ahb) begin
        if (!i_rstn_ahb) begin
            for (int i = 0; i < MEM_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else if (d_act && o_hready && d_write && !d_err) begin
            mem[d_idx] <= i_hwdata;              // Write on last data cycle
        end
    end

endmodule

// ==== hdl/ahb_subsys_pkg.sv ====
package ahb_subsys_pkg;

    // ******************************
    // Bus and memory sizing
    // ******************************
    localparam int ADDR_WIDTH = 32;              // Byte address width
    localparam int DATA_WIDTH = 32;              // Word width
    localparam int MEM_WORDS  = 64;              // Memory depth in words
    localparam int IDX_W      = $clog2(MEM_WORDS); // Word index width

    typedef logic [ADDR_WIDTH-1:0] addr_t;       // Byte address
    typedef logic [DATA_WIDTH-1:0] data_t;       // Data word
    typedef logic [1:0]            axi_resp_t;   // AXI BRESP/RRESP
    typedef logic [1:0]            htrans_t;     // AHB HTRANS
    typedef logic [3:0]            wait_cnt_t;   // Wait-state counter
    typedef logic [IDX_W-1:0]      mem_idx_t;    // Memory word index

    localparam addr_t     MEM_BYTES   = addr_t'(MEM_WORDS * 4); // First invalid byte address
    localparam wait_cnt_t WAIT_STATES = 4'd1;    // hready-low cycles per data phase

    // ******************************
    // Encodings
    // ******************************
    localparam axi_resp_t  RESP_OKAY     = 2'b00;
    localparam axi_resp_t  RESP_SLVERR   = 2'b10;
    localparam htrans_t    HTRANS_IDLE   = 2'b00;
    localparam htrans_t    HTRANS_NONSEQ = 2'b10;
    localparam logic [2:0] HSIZE_WORD    = 3'b010; // 32-bit transfer

    typedef struct packed {
        logic  is_write;                         // 1 = write, 0 = read
        addr_t addr;                             // Byte address
        data_t wdata;                            // Write data, unused for reads
    } ahb_req_t;

    typedef struct packed {
        logic  is_write;                         // Kind of completed transfer
        logic  err;                              // AHB ERROR seen
        data_t rdata;                            // Read data from the slave
    } ahb_done_t;

    typedef enum logic [1:0] {
        IDLE,                                    // No address phase on the bus
        NONSEQ,                                  // Address phase driven
        ERR2                                     // Second ERROR cycle, bus idled
    } mst_state_t;

endpackage

// ==== hdl/axil_ahb_subsys.sv ====
module axil_ahb_subsys
    import ahb_subsys_pkg::*;
(
    input  logic       i_clk_ahb,
    input  logic       i_rstn_ahb,
    // AXI4-Lite slave port
    input  logic       i_awvalid,
    input  addr_t      i_awaddr,
    output logic       o_awready,
    input  logic       i_wvalid,
    input  data_t      i_wdata,
    input  logic [3:0] i_wstrb,
    output logic       o_wready,
    output logic       o_bvalid,
    output axi_resp_t  o_bresp,
    input  logic       i_bready,
    input  logic       i_arvalid,
    input  addr_t      i_araddr,
    output logic       o_arready,
    output logic       o_rvalid,
    output data_t      o_rdata,
    output axi_resp_t  o_rresp,
    input  logic       i_rready
);

    logic       req_valid, req_ready;            // Front end to master
    ahb_req_t   req;
    logic       done_valid, done_ready;          // Master to back end
    ahb_done_t  done;
    addr_t      haddr;                           // AHB-Lite bus
    htrans_t    htrans;
    logic       hwrite, hready, hresp;
    logic [2:0] hsize;
    data_t      hwdata, hrdata;

    // ******************************
    // Input side
    // ******************************
    axil_req_front u_front (
        .i_clk_ahb (i_clk_ahb), .i_rstn_ahb (i_rstn_ahb),
        .i_awvalid (i_awvalid), .i_awaddr (i_awaddr), .o_awready (o_awready),
        .i_wvalid (i_wvalid), .i_wdata (i_wdata), .i_wstrb (i_wstrb), .o_wready (o_wready),
        .i_arvalid (i_arvalid), .i_araddr (i_araddr), .o_arready (o_arready),
        .o_req_valid (req_valid), .o_req (req), .i_req_ready (req_ready)
    );

    // ******************************
    // Processing
    // ******************************
    ahb_master u_master (
        .i_clk_ahb (i_clk_ahb), .i_rstn_ahb (i_rstn_ahb),
        .i_req_valid (req_valid), .i_req (req), .o_req_ready (req_ready),
        .o_done_valid (done_valid), .o_done (done), .i_done_ready (done_ready),
        .o_haddr (haddr), .o_htrans (htrans), .o_hwrite (hwrite), .o_hsize (hsize),
        .o_hwdata (hwdata), .i_hrdata (hrdata), .i_hready (hready), .i_hresp (hresp)
    );

    ahb_sram u_sram (
        .i_clk_ahb (i_clk_ahb), .i_rstn_ahb (i_rstn_ahb),
        .i_haddr (haddr), .i_htrans (htrans), .i_hwrite (hwrite), .i_hsize (hsize),
        .i_hwdata (hwdata), .o_hrdata (hrdata), .o_hready (hready), .o_hresp (hresp)
    );

    // ******************************
    // Output side
    // ******************************
    axil_resp_back u_back (
        .i_clk_ahb (i_clk_ahb), .i_rstn_ahb (i_rstn_ahb),
        .i_done_valid (done_valid), .i_done (done), .o_done_ready (done_ready),
        .o_bvalid (o_bvalid), .o_bresp (o_bresp), .i_bready (i_bready),
        .o_rvalid (o_rvalid), .o_rdata (o_rdata), .o_rresp (o_rresp), .i_rready (i_rready)
    );

endmodule

// ==== hdl/axil_req_front.sv ====
module axil_req_front
    import ahb_subsys_pkg::*;
(
    input  logic     i_clk_ahb,
    input  logic     i_rstn_ahb,
    // AXI4-Lite write address / data
    input  logic     i_awvalid,
    input  addr_t    i_awaddr,
    output logic     o_awready,
    input  logic     i_wvalid,
    input  data_t    i_wdata,
    input  logic [3:0] i_wstrb,                  // Full-word writes only, strobes not used
    output logic     o_wready,
    // AXI4-Lite read address
    input  logic     i_arvalid,
    input  addr_t    i_araddr,
    output logic     o_arready,
    // Request toward the AHB master
    output logic     o_req_valid,
    output ahb_req_t o_req,
    input  logic     i_req_ready
);

    logic     rdy_en;                            // Low through reset, high after
    logic     reg_vld;                           // Request register full
    ahb_req_t reg_req;                           // Request register payload
    logic     ar_take;                           // AR handshake this cycle
    logic     wr_take;                           // AW+W handshake this cycle

    // ******************************
    // Acceptance and read priority
    // ******************************
    assign ar_take = rdy_en & ~reg_vld & i_arvalid;
    assign wr_take = rdy_en & ~reg_vld & i_awvalid & i_wvalid & ~i_arvalid; // Read wins

    assign o_arready = rdy_en & ~reg_vld;
    assign o_awready = wr_take;                  // AW and W always go together
    assign o_wready  = wr_take;

    always_ff @(posedge i_clk_ahb or negedge i_rstn_ahb) begin
        if (!i_rstn_ahb) begin
            rdy_en  <= 1'b0;
            reg_vld <= 1'b0;
        end else begin
            rdy_en <= 1'b1;                      // Readies open one cycle after release
            if (ar_take || wr_take) begin
                reg_vld <= 1'b1;
            end else if (i_req_ready) begin
                reg_vld <= 1'b0;                 // Master took the request
            end
        end
    end

    always_ff @(posedge i_clk_ahb) begin
        if (ar_take) begin
            reg_req <= '{is_write: 1'b0, addr: i_araddr, wdata: '0};
        end else if (wr_take) begin
            reg_req <= '{is_write: 1'b1, addr: i_awaddr, wdata: i_wdata};
        end
    end

    assign o_req_valid = reg_vld;
    assign o_req       = reg_req;

endmodule

// ==== hdl/axil_resp_back.sv ====
module axil_resp_back
    import ahb_subsys_pkg::*;
(
    input  logic      i_clk_ahb,
    input  logic      i_rstn_ahb,
    // Completions from the AHB master
    input  logic      i_done_valid,
    input  ahb_done_t i_done,
    output logic      o_done_ready,
    // AXI4-Lite write response
    output logic      o_bvalid,
    output axi_resp_t o_bresp,
    input  logic      i_bready,
    // AXI4-Lite read data
    output logic      o_rvalid,
    output data_t     o_rdata,
    output axi_resp_t o_rresp,
    input  logic      i_rready
);

    logic      b_full;                           // B slot holds a response
    logic      r_full;                           // R slot holds a response
    axi_resp_t resp;                             // Mapped AHB response
    logic      take;                             // Completion accepted

    assign o_done_ready = i_done.is_write ? ~b_full : ~r_full; // Slot of incoming kind
    assign take         = i_done_valid & o_done_ready;
    assign resp         = i_done.err ? RESP_SLVERR : RESP_OKAY;

    // ******************************
    // Slot occupancy
    // ******************************
    always_ff @(posedge i_clk_ahb or negedge i_rstn_ahb) begin
        if (!i_rstn_ahb) begin
            b_full <= 1'b0;
            r_full <= 1'b0;
        end else begin
            if (take && i_done.is_write) begin
                b_full <= 1'b1;
            end else if (i_bready) begin
                b_full <= 1'b0;                  // Drained by B handshake
            end
            if (take && !i_done.is_write) begin
                r_full <= 1'b1;
            end else if (i_rready) begin
                r_full <= 1'b0;                  // Drained by R handshake
            end
        end
    end

    always_ff @(posedge i_clk_ahb) begin
        if (take && i_done.is_write) begin
            o_bresp <= resp;
        end
        if (take && !i_done.is_write) begin
            o_rresp <= resp;
            o_rdata <= i_done.err ? '0 : i_done.rdata; // No data on error
        end
    end

    assign o_bvalid = b_full;
    assign o_rvalid = r_full;

endmodule

// ==== run.sh ====
#!/bin/sh
# Build and run the AXI4-Lite to AHB-Lite testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module tb_axil_ahb -f files.f -o sim_axil_ahb
status=0
./obj_dir/sim_axil_ahb > sim.log 2>&1 || status=$?
cat sim.log
if [ "$status" -ne 0 ] || grep -q "TEST FAILED" sim.log; then
    echo "Simulation failed"
    exit 1
fi
echo "Simulation passed"

// ==== verification/axil_ahb_cases.txt ====
# columns: name op addr wdata resp rdata, hex values, resp 0 OKAY and 2 SLVERR
# ops: W write, R read, WR read and write presented in one cycle
rst_rd_08    R   00000008 00000000 0 00000000
rst_rd_f8    R   000000f8 00000000 0 00000000
wr_10        W   00000010 deadbeef 0 00000000
rd_10        R   00000010 00000000 0 deadbeef
wr_fc        W   000000fc 12345678 0 00000000
rd_fc        R   000000fc 00000000 0 12345678
wr_oor       W   00000100 cafef00d 2 00000000
rd_oor       R   00000104 00000000 2 00000000
rd_00_kept   R   00000000 00000000 0 00000000
wr_20        W   00000020 01020304 0 00000000
rd_b2b_20    R   00000020 00000000 0 01020304
rd_b2b_fc    R   000000fc 00000000 0 12345678
rd_b2b_10    R   00000010 00000000 0 deadbeef
wr_40        W   00000040 aaaa5555 0 00000000
wr_rd_40     WR  00000040 0badf00d 0 aaaa5555
rd_40        R   00000040 00000000 0 0badf00d

// ==== verification/axil_ahb_props.sv ====
module axil_ahb_props
    import ahb_subsys_pkg::*;
(
    input logic      i_clk_ahb,
    input logic      i_rstn_ahb,
    input logic      i_rvalid,
    input data_t     i_rdata,
    input axi_resp_t i_rresp,
    input logic      i_rready,
    input logic      i_bvalid,
    input axi_resp_t i_bresp,
    input logic      i_bready,
    input htrans_t   i_htrans,
    input addr_t     i_haddr,
    input logic      i_hready,
    input logic      i_hresp
);

    // ******************************
    // AXI4-Lite response channels
    // ******************************
    r_hold: assert property (@(posedge i_clk_ahb) disable iff (!i_rstn_ahb)
        i_rvalid && !i_rready |=> i_rvalid && $stable(i_rdata) && $stable(i_rresp))
        else $error("R channel changed before rready");

    b_hold: assert property (@(posedge i_clk_ahb) disable iff (!i_rstn_ahb)
        i_bvalid && !i_bready |=> i_bvalid && $stable(i_bresp))
        else $error("B channel changed before bready");

    // Outputs quiet when reset is released
    rst_quiet: assert property (@(posedge i_clk_ahb)
        $rose(i_rstn_ahb) |-> !i_rvalid && !i_bvalid && (i_htrans == HTRANS_IDLE))
        else $error("Valid or htrans active right after reset");

    // ******************************
    // AHB-Lite address phase
    // ******************************
    addr_stable: assert property (@(posedge i_clk_ahb) disable iff (!i_rstn_ahb)
        (i_htrans == HTRANS_NONSEQ) && !i_hready && !i_hresp
        |=> (i_htrans == HTRANS_NONSEQ) && $stable(i_haddr))
        else $error("Address phase changed during a wait state");

endmodule

bind axil_ahb_subsys axil_ahb_props u_props (
    .i_clk_ahb  (i_clk_ahb),
    .i_rstn_ahb (i_rstn_ahb),
    .i_rvalid   (o_rvalid),
    .i_rdata    (o_rdata),
    .i_rresp    (o_rresp),
    .i_rready   (i_rready),
    .i_bvalid   (o_bvalid),
    .i_bresp    (o_bresp),
    .i_bready   (i_bready),
    .i_htrans   (htrans),                        // Internal AHB bus
    .i_haddr    (haddr),
    .i_hready   (hready),
    .i_hresp    (hresp)
);

// ==== verification/tb_axil_ahb.sv ====
module tb_axil_ahb
    import ahb_subsys_pkg::*;
();

    localparam int          CLK_PERIOD  = 100;
    localparam int          RST_CYCLES  = 10;
    localparam logic [31:0] SEED        = 32'd53698;
    localparam int          TO_PER_CASE = 40;    // Timeout cycles per case
    localparam int          TO_MARGIN   = 100;
    localparam int          MAX_CASES   = 32;

    logic       clk, rstn;
    logic       awvalid, awready, wvalid, wready, arvalid, arready;
    addr_t      awaddr, araddr;
    data_t      wdata, rdata;
    logic [3:0] wstrb;
    logic       bvalid, bready, rvalid, rready;
    axi_resp_t  bresp, rresp;

    string      c_name  [MAX_CASES];             // Case table from the data file
    logic       c_rd    [MAX_CASES];
    logic       c_wr    [MAX_CASES];
    addr_t      c_addr  [MAX_CASES];
    data_t      c_wdata [MAX_CASES];
    data_t      c_resp  [MAX_CASES];
    data_t      c_rdata [MAX_CASES];
    int         c_pend  [MAX_CASES];             // Responses still owed
    logic       c_bad   [MAX_CASES];
    int         n_cases, pass_cnt, fail_cnt;
    int         rq[$];                           // Case index per read in flight
    int         bq[$];                           // Case index per write in flight
    logic [31:0] rng;

    tb_clk_gen #(.PERIOD(CLK_PERIOD)) u_clk (.o_clk(clk));

    axil_ahb_subsys u_dut (
        .i_clk_ahb (clk), .i_rstn_ahb (rstn),
        .i_awvalid (awvalid), .i_awaddr (awaddr), .o_awready (awready),
        .i_wvalid (wvalid), .i_wdata (wdata), .i_wstrb (wstrb), .o_wready (wready),
        .o_bvalid (bvalid), .o_bresp (bresp), .i_bready (bready),
        .i_arvalid (arvalid), .i_araddr (araddr), .o_arready (arready),
        .o_rvalid (rvalid), .o_rdata (rdata), .o_rresp (rresp), .i_rready (rready)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // ******************************
    // Case file and checking
    // ******************************
    task automatic load_cases(output bit ok);
        int              fd, cnt;
        logic [8*96-1:0] line_v;
        logic [8*24-1:0] name_v;
        logic [8*4-1:0]  op_v;
        data_t           addr_v, wdata_v, resp_v, rdata_v;
        string           op_s;
        ok = 1'b1;
        n_cases = 0;
        fd = $fopen("verification/axil_ahb_cases.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the case file verification/axil_ahb_cases.txt");
            ok = 1'b0;
        end else begin
            while (!$feof(fd) && n_cases < MAX_CASES) begin
                line_v = '0;
                cnt = $fgets(line_v, fd);
                if (cnt != 0) begin
                    cnt = $sscanf(line_v, "%s %s %h %h %h %h", name_v, op_v,
                                  addr_v, wdata_v, resp_v, rdata_v);
                end
                if (cnt == 6) begin                  // Comments and blank lines skipped
                    op_s               = string'(op_v);
                    c_name[n_cases]    = string'(name_v);
                    c_rd[n_cases]      = (op_s == "R") || (op_s == "WR");
                    c_wr[n_cases]      = (op_s == "W") || (op_s == "WR");
                    c_addr[n_cases]    = addr_v;
                    c_wdata[n_cases]   = wdata_v;
                    c_resp[n_cases]    = resp_v;
                    c_rdata[n_cases]   = rdata_v;
                    c_pend[n_cases]    = int'(c_rd[n_cases]) + int'(c_wr[n_cases]);
                    c_bad[n_cases]     = 1'b0;
                    if (c_pend[n_cases] == 0) begin
                        $display("Unknown operation %s in case %s", op_s, c_name[n_cases]);
                        ok = 1'b0;
                    end
                    n_cases++;
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic check_value(input int idx, input string field, input data_t exp,
                               input data_t act);
        if (exp !== act) begin
            $display("FAILED %s %s expected %h actual %h", c_name[idx], field, exp, act);
            c_bad[idx] = 1'b1;
        end
    endtask

    task automatic close_part(input int idx);
        c_pend[idx]--;
        if (c_pend[idx] == 0) begin                  // Last response of this case
            if (c_bad[idx]) begin
                fail_cnt++;
                $display("%s: mismatch", c_name[idx]);
            end else begin
                pass_cnt++;
                $display("%s: ok", c_name[idx]);
            end
        end
    endtask

    // ******************************
    // Main sequence
    // ******************************
    initial begin
        bit ok, timed_out, ar_pend, wr_pend, ar_fire, wr_fire, b_fire, r_fire;
        bit b_seen, r_seen;
        int ci, cyc, limit, b_wait, r_wait, idx, stray, hs_err;
        rstn    = 1'b0;
        awvalid = 1'b0;
        awaddr  = '0;
        wvalid  = 1'b0;
        wdata   = '0;
        wstrb   = 4'h0;
        arvalid = 1'b0;
        araddr  = '0;
        bready  = 1'b0;
        rready  = 1'b0;
        pass_cnt  = 0;
        fail_cnt  = 0;
        timed_out = 1'b0;
        ar_pend   = 1'b0;
        wr_pend   = 1'b0;
        b_seen    = 1'b0;
        r_seen    = 1'b0;
        ci        = 0;
        cyc       = 0;
        stray     = 0;
        hs_err    = 0;
        b_wait    = 0;
        r_wait    = 0;
        rng       = SEED;
        load_cases(ok);
        limit = TO_PER_CASE * n_cases + TO_MARGIN;
        repeat (RST_CYCLES) @(posedge clk);
        #1 rstn = 1'b1;
        while (ok && !timed_out && (ci < n_cases || ar_pend || wr_pend
               || rq.size() != 0 || bq.size() != 0)) begin
            @(negedge clk);                          // Mid-cycle sample
            ar_fire = arvalid & arready;
            wr_fire = awvalid & awready & wvalid & wready;
            b_fire  = bvalid & bready;
            r_fire  = rvalid & rready;
            b_seen  = bvalid;
            r_seen  = rvalid;
            if (awready !== wready) begin
                $display("AW and W ready differ, a write could be split");
                hs_err++;
            end
            if (b_fire) begin
                if (bq.size() == 0) begin
                    $display("Write response arrived with no write outstanding");
                    stray++;
                end else begin
                    idx = bq.pop_front();
                    check_value(idx, "bresp", c_resp[idx], data_t'(bresp));
                    close_part(idx);
                end
            end
            if (r_fire) begin
                if (rq.size() == 0) begin
                    $display("Read data arrived with no read outstanding");
                    stray++;
                end else begin
                    idx = rq.pop_front();
                    check_value(idx, "rresp", c_resp[idx], data_t'(rresp));
                    check_value(idx, "rdata", c_rdata[idx], rdata);
                    close_part(idx);
                end
            end
            @(posedge clk);
            #1;
            if (ar_fire) begin
                arvalid = 1'b0;
                ar_pend = 1'b0;
            end
            if (wr_fire) begin
                awvalid = 1'b0;
                wvalid  = 1'b0;
                wr_pend = 1'b0;
            end
            if (!ar_pend && !wr_pend && ci < n_cases) begin // Next op, AR and AW/W together
                if (c_rd[ci]) begin
                    araddr  = c_addr[ci];
                    arvalid = 1'b1;
                    ar_pend = 1'b1;
                    rq.push_back(ci);
                end
                if (c_wr[ci]) begin
                    awaddr  = c_addr[ci];
                    wdata   = c_wdata[ci];
                    wstrb   = 4'hf;
                    awvalid = 1'b1;
                    wvalid  = 1'b1;
                    wr_pend = 1'b1;
                    bq.push_back(ci);
                end
                ci++;
            end
            // Random 0 to 3 low cycles before each acceptance
            if (b_fire) begin
                rng    = xorshift32(rng);
                b_wait = int'(rng[1:0]);
            end else if (b_wait != 0 && b_seen) begin
                b_wait--;                            // Stall counts only while bvalid waits
            end
            if (r_fire) begin
                rng    = xorshift32(rng);
                r_wait = int'(rng[1:0]);
            end else if (r_wait != 0 && r_seen) begin
                r_wait--;                            // Same for rvalid
            end
            bready = (b_wait == 0);
            rready = (r_wait == 0);
            cyc++;
            if (cyc >= limit) begin
                timed_out = 1'b1;
            end
        end
        if (timed_out) begin
            $display("Timeout after %0d cycles, responses still outstanding", cyc);
        end
        $display("Tests passed: %0d, failed: %0d", pass_cnt, fail_cnt);
        if (ok && !timed_out && fail_cnt == 0 && stray == 0 && hs_err == 0
            && n_cases > 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== verification/tb_clk_gen.sv ====
module tb_clk_gen #(
    parameter int PERIOD = 100                   // Clock period in time units
) (
    output logic o_clk
);

    initial begin
        o_clk = 1'b0;
        forever #(PERIOD / 2) o_clk = ~o_clk;    // Even duty cycle
    end

endmodule
